// ==== src/link_test_pkg.sv ====
package link_test_pkg;

	// --------------------
	// counters
	// --------------------

	localparam int cnt_w = 32;

	// frame counts, good counts and programmed frame totals
	typedef logic [cnt_w-1:0] cnt_t;

	// --------------------
	// sequence byte
	// --------------------

	typedef logic [7:0] seq_t;

	localparam seq_t seq_max = 8'hff;   // wraps to 0 after this

	// xor pattern for a damaged sequence byte
	localparam seq_t fault_mask = 8'h80;

	// --------------------
	// checker states
	// --------------------

	typedef enum logic [1:0] {
		idle,        // nothing armed
		wait_zero,   // armed, looking for sequence 0
		running,     // counting frames
		finished     // total reached at a gap
	} chk_state_t;

endpackage

// ==== src/frame_gen.sv ====
`timescale 1ns/1ps

module frame_gen #(
	parameter int frame_len = 16,
	parameter int gap_len = 4,
	parameter int seq_pos = 2
) (
	input logic clk,
	input logic rst,
	input logic start,
	input link_test_pkg::cnt_t num_frames,
	output logic tx_en,
	output link_test_pkg::seq_t tx_data,
	output link_test_pkg::cnt_t frame_idx
);
	import link_test_pkg::*;

	// one offset counter serves both the frame and the gap
	localparam int span = (frame_len > gap_len) ? frame_len : gap_len;
	localparam int off_w = $clog2(span + 1);

	localparam logic [off_w-1:0] frame_last = off_w'(frame_len - 1);
	localparam logic [off_w-1:0] gap_last = off_w'(gap_len - 1);
	localparam logic [off_w-1:0] seq_off = off_w'(seq_pos);

	typedef enum logic [1:0] {
		ph_idle,
		ph_frame,
		ph_gap
	} phase_t;

	phase_t phase;
	logic [off_w-1:0] off;   // byte offset in frame, or cycle in gap
	cnt_t frame_cnt;         // frames sent so far
	logic can_start;

	// a start inside a frame is dropped so frames are never cut short
	assign can_start = start && (num_frames != '0) && (phase != ph_frame);

	// --------------------
	// phase machine
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= ph_idle;
			off <= '0;
			frame_cnt <= '0;
		end else if (can_start) begin
			phase <= ph_frame;
			off <= '0;
			frame_cnt <= '0;
		end else begin
			case (phase)
				ph_frame: begin
					if (off == frame_last) begin
						phase <= ph_gap;
						off <= '0;
						frame_cnt <= frame_cnt + 1;
					end else begin
						off <= off + off_w'(1);
					end
				end

				ph_gap: begin
					if (off == gap_last) begin
						off <= '0;
						// last gap done, back to idle
						if (frame_cnt >= num_frames)
							phase <= ph_idle;
						else
							phase <= ph_frame;
					end else begin
						off <= off + off_w'(1);
					end
				end

				default: begin
					off <= '0;
				end
			endcase
		end
	end

	// --------------------
	// byte stream
	// --------------------

	assign tx_en = (phase == ph_frame);

	// sequence number is frame index mod 256, filler is the offset
	assign tx_data = (off == seq_off) ? seq_t'(frame_cnt) : seq_t'(off);

	assign frame_idx = frame_cnt;   // only meaningful while tx_en

	// every frame is followed by at least one idle cycle
	a_frame_len: assert property (
		@(posedge clk) disable iff (rst)
		tx_en [*frame_len] |=> !tx_en
	);

endmodule

// ==== src/frame_fault.sv ====
`timescale 1ns/1ps

module frame_fault #(
	parameter int seq_pos = 2
) (
	input logic clk,
	input logic rst,
	input logic tx_en,
	input link_test_pkg::seq_t tx_data,
	input link_test_pkg::cnt_t frame_idx,
	input link_test_pkg::cnt_t fault_period,
	output logic rx_en,
	output link_test_pkg::seq_t rx_data
);
	import link_test_pkg::*;

	// offset only has to reach seq_pos, then it saturates
	localparam int off_w = $clog2(seq_pos + 2);
	localparam logic [off_w-1:0] seq_off = off_w'(seq_pos);
	localparam logic [off_w-1:0] off_sat = off_w'(seq_pos + 1);

	logic [off_w-1:0] off;   // offset of the byte now on tx_data
	cnt_t pcnt;              // position of the frame in its fault period
	cnt_t pcnt_next;
	cnt_t pcnt_cur;
	logic first_byte;
	logic hit;

	assign first_byte = tx_en && (off == '0);

	// period restarts with frame 0 or after its last frame
	assign pcnt_next = (frame_idx == '0 || pcnt == fault_period) ? cnt_t'(1) : pcnt + 1;
	assign pcnt_cur = first_byte ? pcnt_next : pcnt;

	assign hit = tx_en && (off == seq_off) && (fault_period != '0)
		&& (pcnt_cur == fault_period);

	// --------------------
	// control
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			off <= '0;
			pcnt <= '0;
			rx_en <= 1'b0;
		end else begin
			rx_en <= tx_en;
			if (!tx_en)
				off <= '0;
			else if (off != off_sat)
				off <= off + off_w'(1);
			if (first_byte)
				pcnt <= pcnt_next;
		end
	end

	// payload, one cycle behind tx
	always_ff @(posedge clk) begin
		rx_data <= hit ? (tx_data ^ fault_mask) : tx_data;
	end

	// a period of 1 would damage frame 0 and the checker never starts
	a_period: assert property (
		@(posedge clk) disable iff (rst)
		tx_en |-> (fault_period != cnt_t'(1))
	);

endmodule

// ==== src/seq_checker.sv ====
`timescale 1ns/1ps

module seq_checker #(
	parameter int seq_pos = 2
) (
	input logic clk,
	input logic rst,
	input logic start,
	input link_test_pkg::cnt_t num_frames,
	input logic rx_en,
	input link_test_pkg::seq_t rx_data,
	output link_test_pkg::cnt_t count,
	output link_test_pkg::cnt_t ok,
	output logic valid,
	output logic done,
	output link_test_pkg::chk_state_t state
);
	import link_test_pkg::*;

	// edge counter saturates past the compare slot
	localparam int off_w = $clog2(seq_pos + 3);
	localparam logic [off_w-1:0] seq_off = off_w'(seq_pos);
	localparam logic [off_w-1:0] seq_off_1 = off_w'(seq_pos + 1);
	localparam logic [off_w-1:0] off_sat = off_w'(seq_pos + 2);

	logic [off_w-1:0] off;   // bytes seen in this frame
	seq_t seq_cur;           // sequence of the current frame
	seq_t seq_prev;          // sequence of the frame before
	seq_t seq_exp;
	logic seq_on;            // sequence byte on rx_data
	logic seq_on_1;          // one byte later, compare slot
	logic seq_match;

	assign seq_on = rx_en && (off == seq_off);
	assign seq_on_1 = rx_en && (off == seq_off_1);

	// expected value wraps 255 -> 0
	assign seq_exp = (seq_prev == seq_max) ? '0 : seq_prev + 8'd1;
	assign seq_match = (seq_cur == seq_exp);

	assign done = (state == finished);

	// --------------------
	// frame offset
	// --------------------

	always_ff @(posedge clk) begin
		if (rst)
			off <= '0;
		else if (!rx_en)
			off <= '0;   // gap restarts the count
		else if (off != off_sat)
			off <= off + off_w'(1);
	end

	// sequence capture, damaged values kept as they came
	always_ff @(posedge clk) begin
		if (seq_on) begin
			seq_cur <= rx_data;
			seq_prev <= seq_cur;
		end
	end

	// --------------------
	// state machine
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			count <= '0;
			ok <= '0;
			valid <= 1'b0;
		end else begin
			valid <= rx_en && (state != idle);
			if (start) begin
				// re-arm from any state
				state <= wait_zero;
				count <= '0;
				ok <= '0;
			end else begin
				case (state)
					wait_zero: begin
						if (seq_on_1 && seq_cur == '0) begin
							count <= cnt_t'(1);
							ok <= cnt_t'(1);
							state <= running;
						end
					end

					running: begin
						if (seq_on_1) begin
							count <= count + 1;
							if (seq_match)
								ok <= ok + 1;
						end else if (!rx_en && count == num_frames) begin
							state <= finished;
						end
					end

					default: begin
						state <= state;   // idle and finished hold
					end
				endcase
			end
		end
	end

	// --------------------
	// checks
	// --------------------

	a_ok_le_count: assert property (
		@(posedge clk) disable iff (rst)
		ok <= count
	);

	// total is stable while a run is counting
	a_count_bound: assert property (
		@(posedge clk) disable iff (rst)
		(state == running) |-> (count <= num_frames)
	);

endmodule

// ==== src/link_test_top.sv ====
`timescale 1ns/1ps

module link_test_top #(
	parameter int frame_len = 16,
	parameter int gap_len = 4,
	parameter int seq_pos = 2
) (
	input logic clk,
	input logic rst,
	input logic start,
	input link_test_pkg::cnt_t num_frames,
	input link_test_pkg::cnt_t fault_period,
	output link_test_pkg::cnt_t count,
	output link_test_pkg::cnt_t ok,
	output logic valid,
	output logic done,
	output link_test_pkg::chk_state_t state
);
	import link_test_pkg::*;

	// --------------------
	// stream wires
	// --------------------

	logic tx_en;
	seq_t tx_data;
	cnt_t frame_idx;
	logic rx_en;    // tx delayed one cycle
	seq_t rx_data;

	frame_gen #(
		.frame_len(frame_len),
		.gap_len(gap_len),
		.seq_pos(seq_pos)
	) frame_gen_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.num_frames(num_frames),
		.tx_en(tx_en),
		.tx_data(tx_data),
		.frame_idx(frame_idx)
	);

	frame_fault #(
		.seq_pos(seq_pos)
	) frame_fault_i (
		.clk(clk),
		.rst(rst),
		.tx_en(tx_en),
		.tx_data(tx_data),
		.frame_idx(frame_idx),
		.fault_period(fault_period),
		.rx_en(rx_en),
		.rx_data(rx_data)
	);

	// checker sees only the received stream
	seq_checker #(
		.seq_pos(seq_pos)
	) seq_checker_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.num_frames(num_frames),
		.rx_en(rx_en),
		.rx_data(rx_data),
		.count(count),
		.ok(ok),
		.valid(valid),
		.done(done),
		.state(state)
	);

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int period = 10,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// reset released on a falling edge, like every other input
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== verif/link_test_tb.sv ====
`timescale 1ns/1ps

module link_test_tb;
	import link_test_pkg::*;

	localparam int frame_len = 16;   // dut defaults
	localparam int gap_len = 4;
	localparam int idle_cycles = 20;
	localparam string pattern_file = "verif/link_test_patterns.txt";

	logic clk;
	logic rst;
	logic start;
	cnt_t num_frames;
	cnt_t fault_period;
	cnt_t count;
	cnt_t ok;
	logic valid;
	logic done;
	chk_state_t state;

	// one entry per pattern line
	string names[$];
	cnt_t frames_q[$];
	cnt_t period_q[$];
	cnt_t exp_count_q[$];
	cnt_t exp_ok_q[$];

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	int cycle_limit = 0;   // 0 until the patterns are loaded
	string cur_test = "reset_idle";
	logic loaded;

	tb_clock clock_i (
		.clk(clk),
		.rst(rst)
	);

	link_test_top dut_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.num_frames(num_frames),
		.fault_period(fault_period),
		.count(count),
		.ok(ok),
		.valid(valid),
		.done(done),
		.state(state)
	);

	// --------------------
	// watchdog
	// --------------------

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("done never rose in test %s", cur_test);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------
	// compare tasks
	// --------------------

	task automatic check_cnt(input string test, input string what,
			input cnt_t expected, input cnt_t actual);
		if (actual !== expected) begin
			$display("error %s: %s expected %0d actual %0d", test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_state(input string test, input chk_state_t expected,
			input chk_state_t actual);
		if (actual !== expected) begin
			$display("error %s: state expected %s actual %s", test, expected.name(),
				actual.name());
			errors++;
		end
	endtask

	task automatic check_bit(input string test, input string what,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s: %s expected %b actual %b", test, what, expected, actual);
			errors++;
		end
	endtask

	// --------------------
	// pattern file
	// --------------------

	task automatic load_patterns(output logic success);
		int fd;
		int n;
		string tok;
		string rest;
		cnt_t f;
		cnt_t p;
		cnt_t ec;
		cnt_t eo;
		success = 1'b0;
		fd = $fopen(pattern_file, "r");
		if (fd == 0) begin
			$display("cannot open pattern file %s", pattern_file);
		end else begin
			while (1) begin
				n = $fscanf(fd, "%s", tok);
				if (n != 1)
					break;
				if (tok[0] == "#") begin
					n = $fgets(rest, fd);   // rest of a comment line
				end else begin
					n = $fscanf(fd, "%d %d %d %d", f, p, ec, eo);
					if (n != 4) begin
						$display("pattern line for %s is malformed", tok);
						errors++;
						break;
					end
					names.push_back(tok);
					frames_q.push_back(f);
					period_q.push_back(p);
					exp_count_q.push_back(ec);
					exp_ok_q.push_back(eo);
				end
			end
			$fclose(fd);
			success = (names.size() != 0);
			if (!success)
				$display("pattern file %s holds no tests", pattern_file);
		end
	endtask

	// every frame takes frame_len + gap_len cycles plus some slack
	function automatic int run_limit();
		int total;
		total = 100;
		foreach (frames_q[i])
			total += int'(frames_q[i]) * (frame_len + gap_len + 2);
		return total;
	endfunction

	function automatic void report_test(input string test, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s passed", test);
		end else begin
			$display("test %s failed", test);
			tests_failed++;
		end
	endfunction

	// --------------------
	// tests
	// --------------------

	// nothing may move without a start
	task automatic check_idle();
		int errs_before;
		logic done_seen;
		logic valid_seen;
		logic count_seen;
		errs_before = errors;
		done_seen = 1'b0;
		valid_seen = 1'b0;
		count_seen = 1'b0;
		repeat (idle_cycles) begin
			@(negedge clk);
			done_seen |= done;
			valid_seen |= valid;
			count_seen |= (count != '0);
		end
		check_bit(cur_test, "done seen", 1'b0, done_seen);
		check_bit(cur_test, "valid seen", 1'b0, valid_seen);
		check_bit(cur_test, "nonzero count seen", 1'b0, count_seen);
		check_state(cur_test, idle, state);
		report_test(cur_test, errs_before);
	endtask

	task automatic run_test(input int i);
		int errs_before;
		cnt_t valid_cycles;
		errs_before = errors;
		valid_cycles = '0;
		cur_test = names[i];
		@(negedge clk);
		num_frames = frames_q[i];
		fault_period = period_q[i];
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// start must clear what the last run left behind
		check_cnt(cur_test, "count after start", '0, count);
		check_cnt(cur_test, "ok after start", '0, ok);
		check_bit(cur_test, "done after start", 1'b0, done);
		// valid is high once for every received byte of the run
		while (done !== 1'b1) begin
			if (valid === 1'b1)
				valid_cycles = valid_cycles + 1;
			@(negedge clk);
		end
		check_cnt(cur_test, "count", exp_count_q[i], count);
		check_cnt(cur_test, "ok", exp_ok_q[i], ok);
		check_cnt(cur_test, "valid cycles", cnt_t'(frames_q[i] * frame_len), valid_cycles);
		check_state(cur_test, finished, state);
		report_test(cur_test, errs_before);
	endtask

	initial begin
		start = 1'b0;
		num_frames = '0;
		fault_period = '0;
		load_patterns(loaded);
		cycle_limit = run_limit();
		@(posedge clk);
		while (rst !== 1'b0)
			@(posedge clk);
		if (!loaded) begin
			$display("FAIL: see errors above");
			$finish;
		end else begin
			check_idle();
			for (int i = 0; i < names.size(); i++)
				run_test(i);
			$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
			if (errors == 0) begin
				$display("PASS: all tests");
			end else begin
				$display("FAIL: see errors above");
			end
			$finish;
		end
	end

endmodule

// ==== verif/link_test_patterns.txt ====
# name frames fault_period expected_count expected_ok
# fault_period 0 means no faults, frame k damaged when (k+1) % period == 0
no_fault 5 0 5 5
wrap 300 0 300 300
fault_mid 10 4 10 6
fault_last 6 3 6 3
restart_clean 8 0 8 8
period_two 5 2 5 1
fault_wide 12 5 12 8

// ==== src.f ====
src/link_test_pkg.sv
src/frame_gen.sv
src/frame_fault.sv
src/seq_checker.sv
src/link_test_top.sv
verif/tb_clock.sv
verif/link_test_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= link_test_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
